// File: vlog.f
+incdir+rtl
rtl/fb_pkg.sv
rtl/uart_rx.sv
rtl/fb_writer.sv
rtl/frame_ram.sv
rtl/vga_timing.sv
rtl/pixel_fetch.sv
rtl/uart_vga_fb.sv
dv/tb_clk_gen.sv
dv/uart_vga_fb_asserts.sv
dv/uart_vga_fb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module uart_vga_fb_tb -o uart_vga_fb_sim

out=$(./obj_dir/uart_vga_fb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: dv/uart_vga_fb_tb.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module uart_vga_fb_tb import fb_pkg::*; ();

    localparam int     CPB           = `FB_CLKS_PER_BIT;
    localparam int     NUM_TESTS     = 5;
    localparam longint FRAME_CLKS    = `FB_H_TOTAL * `FB_PIX_DIV * `FB_V_TOTAL;
    localparam longint WATCHDOG_CLKS = (NUM_TESTS * 4 + 2) * FRAME_CLKS;

    logic        clk;
    logic        rst;
    logic        rx;
    video_t      video;
    fb_addr_t    wr_ptr;
    int unsigned cyc = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          model_ptr;
    fb_pixel_t   model_mem [`FB_DEPTH];
    video_t      line_buf [2][`FB_H_ACTIVE];

    tb_clk_gen tb_clk_gen_inst (
        .clk (clk)
    );

    uart_vga_fb uart_vga_fb_inst (
        .clk    (clk),
        .rst    (rst),
        .rx     (rx),
        .video  (video),
        .wr_ptr (wr_ptr)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    // Outputs are settled 2 ns after the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic video_bit(input string sig);
        case (sig)
            "h_sync": return video.h_sync;
            "v_sync": return video.v_sync;
            default:  return video.de;
        endcase
    endfunction

    task automatic wait_for(input string sig, input logic lvl);
        while (video_bit(sig) !== lvl) step();
    endtask

    // 00RRGGBB, each pair widened with two zero bits
    function automatic logic [11:0] colour_of(input fb_pixel_t b);
        return {b[5:4], 2'b00, b[3:2], 2'b00, b[1:0], 2'b00};
    endfunction

    function automatic logic [11:0] rgb_of(input video_t v);
        return {v.r, v.g, v.b};
    endfunction

    task automatic send_byte(input fb_pixel_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clk);
        #1;
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (CPB) @(posedge clk);
            #1;
        end
        // Idle gap covers the strobe and the memory write
        repeat (2 * CPB) @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input fb_pixel_t b);
        send_byte(b);
        if (b[7]) begin
            model_ptr = 0;
        end else begin
            model_mem[model_ptr] = b;
            model_ptr = (model_ptr == `FB_DEPTH - 1) ? 0 : model_ptr + 1;
        end
    endtask

    // First two active lines of the next frame
    task automatic capture_frame();
        int n;
        wait_for("v_sync", 1'b1);
        wait_for("v_sync", 1'b0);
        for (int l = 0; l < 2; l++) begin
            wait_for("de", 1'b1);
            n = 0;
            while (video.de) begin
                if (n < `FB_H_ACTIVE) line_buf[l][n] = video;
                n++;
                repeat (`FB_PIX_DIV) step();
            end
            check($sformatf("line %0d sample count", l), n, `FB_H_ACTIVE);
        end
    endtask

    // Both lines show stored row 0, each pixel twice
    task automatic check_samples(input int count, input int lines);
        for (int l = 0; l < lines; l++) begin
            for (int i = 0; i < count; i++) begin
                check($sformatf("line %0d sample %0d rgb", l, i), 32'(rgb_of(line_buf[l][i])),
                      32'(colour_of(model_mem[i / `FB_SCALE])));
            end
        end
    endtask

    task automatic test_sync_blanking();
        int unsigned t0;
        check("wr_ptr", 32'(wr_ptr), 0);
        wait_for("h_sync", 1'b1);
        wait_for("h_sync", 1'b0);
        t0 = cyc;
        wait_for("h_sync", 1'b1);
        check("h_sync low clocks", cyc - t0, `FB_H_SYNC * `FB_PIX_DIV);
        wait_for("h_sync", 1'b0);
        check("h_sync period clocks", cyc - t0, `FB_H_TOTAL * `FB_PIX_DIV);
        wait_for("de", 1'b1);
        t0 = cyc;
        wait_for("de", 1'b0);
        check("de high clocks", cyc - t0, `FB_H_ACTIVE * `FB_PIX_DIV);
        // Vertical sync spans whole lines
        wait_for("v_sync", 1'b1);
        wait_for("v_sync", 1'b0);
        t0 = cyc;
        wait_for("v_sync", 1'b1);
        check("v_sync low clocks", cyc - t0, `FB_V_SYNC * `FB_H_TOTAL * `FB_PIX_DIV);
    endtask

    task automatic test_pixel_write();
        fb_pixel_t bytes [4] = '{8'h30, 8'h0c, 8'h03, 8'h3f};
        write_byte(8'h80);
        foreach (bytes[k]) write_byte(bytes[k]);
        check("wr_ptr", 32'(wr_ptr), 4);
        capture_frame();
        check_samples(16, 2);
        for (int i = 8; i < 16; i++) begin
            check($sformatf("line 0 sample %0d black", i), 32'(rgb_of(line_buf[0][i])), 0);
            check($sformatf("line 1 sample %0d black", i), 32'(rgb_of(line_buf[1][i])), 0);
        end
    endtask

    task automatic test_pointer_reset();
        write_byte(8'h80);
        write_byte(8'h21);
        check("wr_ptr", 32'(wr_ptr), 1);
        capture_frame();
        check_samples(8, 2);
    endtask

    task automatic test_colour_map();
        fb_pixel_t bytes [8] = '{8'h15, 8'h55, 8'h2a, 8'h6a, 8'h3f, 8'h7f, 8'h00, 8'h40};
        video_t    s;
        write_byte(8'h80);
        foreach (bytes[k]) write_byte(bytes[k]);
        capture_frame();
        check_samples(16, 2);
        // Bit 6 is not part of the colour
        for (int k = 0; k < 4; k++) begin
            check($sformatf("pixel %0d rgb", 2 * k + 1), 32'(rgb_of(line_buf[0][4 * k + 2])),
                  32'(colour_of(bytes[2 * k])));
        end
        for (int l = 0; l < 2; l++) begin
            for (int i = 0; i < `FB_H_ACTIVE; i++) begin
                s = line_buf[l][i];
                check($sformatf("line %0d sample %0d low bits", l, i),
                      32'({s.r[1:0], s.g[1:0], s.b[1:0]}), 0);
            end
        end
    endtask

    task automatic test_random_fill();
        write_byte(8'h80);
        for (int k = 0; k < 16; k++) begin
            write_byte(fb_pixel_t'($urandom() & 32'h7f));
        end
        check("wr_ptr", 32'(wr_ptr), 32'(model_ptr));
        capture_frame();
        check_samples(32, 1);
    endtask

    initial begin
        void'($urandom(71));
        rst = 1'b1;
        rx  = 1'b1;
        model_ptr = 0;
        for (int i = 0; i < `FB_DEPTH; i++) model_mem[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_sync_blanking();
        test_pixel_write();
        test_pointer_reset();
        test_colour_map();
        test_random_fill();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: dv/uart_vga_fb_asserts.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module uart_vga_fb_asserts import fb_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     rx_valid,
    input video_t   video,
    input fb_addr_t wr_ptr
);

    // Blanking outside the active window
    a_blank: assert property (@(posedge clk) disable iff (rst)
        !video.de |-> (video.r == '0 && video.g == '0 && video.b == '0))
        else $error("Colour output is not zero while de is low");

    // Byte strobe lasts one clock
    a_strobe: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid)
        else $error("rx_valid stayed high for two cycles");

    a_ptr_range: assert property (@(posedge clk) disable iff (rst)
        int'(wr_ptr) < `FB_DEPTH)
        else $error("wr_ptr is outside the frame memory");

endmodule

bind uart_vga_fb uart_vga_fb_asserts uart_vga_fb_asserts_inst (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .video    (video),
    .wr_ptr   (wr_ptr)
);

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // 10 ns period
    localparam int HALF_NS = 5;

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

// File: rtl/uart_vga_fb.sv
`timescale 1ns/1ps

module uart_vga_fb import fb_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rx,
    output video_t   video,
    output fb_addr_t wr_ptr
);

    fb_pixel_t rx_data;
    logic      rx_valid;
    fb_wr_t    wr;
    fb_coord_t coord;
    logic      h_sync;
    logic      v_sync;
    fb_addr_t  rd_addr;
    fb_pixel_t rd_data;

    uart_rx uart_rx_inst (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    fb_writer fb_writer_inst (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .wr       (wr),
        .wr_ptr   (wr_ptr)
    );

    frame_ram frame_ram_inst (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Fetch pipeline runs every clock; the tick only paces the counters
    vga_timing vga_timing_inst (
        .clk      (clk),
        .rst      (rst),
        .pix_tick (),
        .coord    (coord),
        .h_sync   (h_sync),
        .v_sync   (v_sync)
    );

    pixel_fetch pixel_fetch_inst (
        .clk     (clk),
        .rst     (rst),
        .coord   (coord),
        .h_sync  (h_sync),
        .v_sync  (v_sync),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .video   (video)
    );

endmodule

// File: rtl/pixel_fetch.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module pixel_fetch import fb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  fb_coord_t coord,
    input  logic      h_sync,
    input  logic      v_sync,
    output fb_addr_t  rd_addr,
    input  fb_pixel_t rd_data,
    output video_t    video
);

    localparam fb_addr_t RES_X = fb_addr_t'(`FB_RES_X);
    localparam video_t VIDEO_IDLE = '{r: '0, g: '0, b: '0,
                                      h_sync: 1'b1, v_sync: 1'b1, de: 1'b0};

    logic act_d;
    logic hs_d;
    logic vs_d;

    // Two stored bits widen to a full channel, low bits zero
    function automatic logic [`FB_COLOR_W-1:0] chan(input logic [1:0] v);
        return {v, {(`FB_COLOR_W - 2){1'b0}}};
    endfunction

    // Each stored pixel covers a 2x2 block on screen
    assign rd_addr = fb_addr_t'(coord.x / `FB_SCALE)
                   + fb_addr_t'(coord.y / `FB_SCALE) * RES_X;

    // Stage 1 runs alongside the memory read
    always_ff @(posedge clk) begin
        if (rst) begin
            act_d <= 1'b0;
            hs_d  <= 1'b1;
            vs_d  <= 1'b1;
        end else begin
            act_d <= coord.active;
            hs_d  <= h_sync;
            vs_d  <= v_sync;
        end
    end

    // Stage 2 output register, blanked outside the window
    always_ff @(posedge clk) begin
        if (rst) begin
            video <= VIDEO_IDLE;
        end else begin
            video.de     <= act_d;
            video.h_sync <= hs_d;
            video.v_sync <= vs_d;
            video.r      <= act_d ? chan(rd_data[5:4]) : '0;
            video.g      <= act_d ? chan(rd_data[3:2]) : '0;
            video.b      <= act_d ? chan(rd_data[1:0]) : '0;
        end
    end

endmodule

// File: rtl/vga_timing.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module vga_timing import fb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output logic      pix_tick,
    output fb_coord_t coord,
    output logic      h_sync,
    output logic      v_sync
);

    localparam int DIV_W = (`FB_PIX_DIV > 1) ? $clog2(`FB_PIX_DIV) : 1;
    localparam int HW    = `FB_H_W;
    localparam int VW    = `FB_V_W;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`FB_PIX_DIV - 1);
    localparam logic [HW-1:0] H_LAST  = HW'(`FB_H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST  = VW'(`FB_V_TOTAL - 1);
    localparam logic [HW-1:0] H_SYNC  = HW'(`FB_H_SYNC);
    localparam logic [VW-1:0] V_SYNC  = VW'(`FB_V_SYNC);
    localparam logic [HW-1:0] H_START = HW'(`FB_H_START);
    localparam logic [VW-1:0] V_START = VW'(`FB_V_START);
    localparam logic [HW-1:0] H_END   = HW'(`FB_H_START + `FB_H_ACTIVE);
    localparam logic [VW-1:0] V_END   = VW'(`FB_V_START + `FB_V_ACTIVE);

    logic [DIV_W-1:0] div_cnt;
    logic [HW-1:0]    h_cnt;
    logic [VW-1:0]    v_cnt;
    logic             h_act;
    logic             v_act;

    // Pixel clock enable
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= pix_tick ? '0 : div_cnt + 1'b1;
        end
    end

    assign pix_tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_tick) begin
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Syncs are active low at the start of each count
    assign h_sync = (h_cnt >= H_SYNC);
    assign v_sync = (v_cnt >= V_SYNC);

    assign h_act = (h_cnt >= H_START) && (h_cnt < H_END);
    assign v_act = (v_cnt >= V_START) && (v_cnt < V_END);

    always_comb begin
        coord.active = h_act && v_act;
        coord.x      = coord.active ? h_cnt - H_START : '0;
        coord.y      = coord.active ? v_cnt - V_START : '0;
    end

endmodule

// File: rtl/frame_ram.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module frame_ram import fb_pkg::*; (
    input  logic      clk,
    input  fb_wr_t    wr,
    input  fb_addr_t  rd_addr,
    output fb_pixel_t rd_data
);

    // Blank frame at start, as block RAM init
    fb_pixel_t mem [`FB_DEPTH] = '{default: '0};

    // Port A writes only
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Port B reads only; same-address collision returns the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/fb_writer.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module fb_writer import fb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  fb_pixel_t rx_data,
    input  logic      rx_valid,
    output fb_wr_t    wr,
    output fb_addr_t  wr_ptr
);

    localparam fb_addr_t PTR_LAST = fb_addr_t'(`FB_DEPTH - 1);

    logic is_cmd;

    // Bit 7 marks a command byte
    assign is_cmd = rx_data[7];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.en  <= 1'b0;
            wr_ptr <= '0;
        end else begin
            wr.en <= 1'b0;
            if (rx_valid) begin
                if (is_cmd) begin
                    // Home the pointer, nothing is stored
                    wr_ptr <= '0;
                end else begin
                    wr.en   <= 1'b1;
                    wr.addr <= wr_ptr;
                    wr.data <= rx_data;
                    if (wr_ptr == PTR_LAST) begin
                        wr_ptr <= '0;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "fb_params.svh"

module uart_rx import fb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rx,
    output fb_pixel_t rx_data,
    output logic      rx_valid
);

    localparam int CW = `FB_CNT_W;
    localparam logic [CW-1:0] HALF_LAST = CW'((`FB_CLKS_PER_BIT - 1) / 2);
    localparam logic [CW-1:0] BIT_LAST  = CW'(`FB_CLKS_PER_BIT - 1);

    logic            rx_meta;
    logic            rx_sync;
    rx_state_e       state;
    logic [CW-1:0]   cnt;
    logic [3:0]      bit_idx;
    logic            bit_done;
    fb_pixel_t       shreg;

    // Line idles high, so the synchroniser comes out of reset high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_done = (cnt == BIT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt <= '0;
                        // A glitch that is gone by mid start bit is dropped
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        cnt <= '0;
                        if (bit_idx == 4'd8) begin
                            // Now in the middle of the stop bit
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        cnt      <= '0;
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done && bit_idx != 4'd8) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (state == RX_STOP && bit_done) begin
            rx_data <= shreg;
        end
    end

endmodule

// File: rtl/fb_pkg.sv
`include "fb_params.svh"

package fb_pkg;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

    // Stored byte, 00RRGGBB
    typedef logic [7:0] fb_pixel_t;

    typedef struct packed {
        logic      en;
        fb_addr_t  addr;
        fb_pixel_t data;
    } fb_wr_t;

    // Scan position inside the visible window
    typedef struct packed {
        logic                active;
        logic [`FB_H_W-1:0]  x;
        logic [`FB_V_W-1:0]  y;
    } fb_coord_t;

    typedef struct packed {
        logic [`FB_COLOR_W-1:0] r;
        logic [`FB_COLOR_W-1:0] g;
        logic [`FB_COLOR_W-1:0] b;
        logic                   h_sync;
        logic                   v_sync;
        logic                   de;
    } video_t;

endpackage

// File: rtl/fb_params.svh
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// UART bit timing
`define FB_CLKS_PER_BIT 50
`define FB_CNT_W        8

// 640x480 video timing, counted in pixel ticks
`define FB_PIX_DIV      2
`define FB_H_TOTAL      800
`define FB_V_TOTAL      525
`define FB_H_SYNC       96
`define FB_V_SYNC       2
`define FB_H_START      144
`define FB_V_START      35
`define FB_H_ACTIVE     640
`define FB_V_ACTIVE     480
`define FB_H_W          10
`define FB_V_W          10

// Stored frame, doubled on both axes
`define FB_RES_X        320
`define FB_RES_Y        240
`define FB_SCALE        2
`define FB_DEPTH        76800
`define FB_ADDR_W       17
`define FB_COLOR_W      4

`endif
